// ==== csiRxController.f ====
src/csiProtoPkg.sv
src/videoPkg.sv
src/csiLaneMerge.sv
src/csiPacketParser.sv
src/pixelFifo.sv
src/csiRxController.sv
dv/csiRxController_sva.sv
dv/csiRxController_tb.sv

// ==== dv/csiRxController_sva.sv ====
`timescale 1ns/1ps
// Port timing assertions for the CSI-2 receive controller
// Sink read timing, header strobe width and sticky error flags
module csiRxController_sva
(
	input	logic	iSCLK,
	input	logic	iSRST,
	input	logic	iVideoFull,
	input	logic	oVideoVd,
	input	logic	oHsValid,
	input	logic	oFifoOvf,
	input	logic	oErrTrunc
);

	int failCnt;	// Failed assertions so far
	initial failCnt = 0;

	// Read only when the sink had room
	apReadRoom: assert property (@(posedge iSCLK) disable iff (iSRST)
		oVideoVd |-> $past(!iVideoFull))
		else
		begin
			failCnt++;
			$error("oVideoVd without sink room one cycle earlier");
		end

	apHdrPulse: assert property (@(posedge iSCLK) disable iff (iSRST)
		oHsValid |=> !oHsValid)	// Single cycle strobe
		else
		begin
			failCnt++;
			$error("oHsValid longer than one cycle");
		end

	// --------------------
	// Sticky flags
	// --------------------
	apOvfHeld: assert property (@(posedge iSCLK) disable iff (iSRST)
		$past(oFifoOvf) |-> oFifoOvf)
		else
		begin
			failCnt++;
			$error("oFifoOvf fell outside reset");
		end

	apTruncHeld: assert property (@(posedge iSCLK) disable iff (iSRST)
		$past(oErrTrunc) |-> oErrTrunc)
		else
		begin
			failCnt++;
			$error("oErrTrunc fell outside reset");
		end

endmodule

bind csiRxController csiRxController_sva i_csiRxController_sva (
	.iSCLK(iSCLK),			.iSRST(iSRST),
	.iVideoFull(iVideoFull),	.oVideoVd(oVideoVd),
	.oHsValid(oHsValid),		.oFifoOvf(oFifoOvf),
	.oErrTrunc(oErrTrunc)
);

// ==== dv/csiRxController_tb.sv ====
`timescale 1ns/1ps
// CSI-2 receive controller testbench
// Directed tests over the two HS lanes: long and short packets, sink
// back-pressure with FIFO overflow, truncated bursts and SOT errors.
// Payload words come from an LFSR, output words are collected by a monitor
module csiRxController_tb;

	localparam int lpMaxCycles = 3000;	// Well above the test length
	localparam int lpSettle    = 12;	// Cycles to see stray words

	logic					iSCLK;
	logic					iSRST;
	logic					iRxValidHsLan0;
	logic					iRxValidHsLan1;
	csiProtoPkg::tLaneByte	iRxDataHsLan0;
	csiProtoPkg::tLaneByte	iRxDataHsLan1;
	logic					iErrSotHsLan0;
	logic					iErrSotHsLan1;
	logic					iVideoFull;
	csiProtoPkg::tDataType	oHsDatatype;
	csiProtoPkg::tVc		oHsVc;
	csiProtoPkg::tWordCnt	oHsWordCnt;
	csiProtoPkg::tEcc		oHsEcc;
	logic					oHsValid;
	videoPkg::tPixelWord	oVideoPixel;
	logic					oVideoVd;
	logic					oCdcFifoFull;
	logic					oFifoOvf;
	logic					oErrSot;
	logic					oErrTrunc;

	logic [31:0]			lfsrState;
	videoPkg::tPixelWord	txWords[$];	// Payload of the current packet
	videoPkg::tPixelWord	rxWords[$];	// Words seen on oVideoVd
	int						hdrCount;
	int						cycleCnt;

	csiRxController #(.pFifoDepth(16), .pFullMargin(4)) i_csiRxController (.*);

	initial
	begin
		iSCLK = 1'b0;
		forever #10 iSCLK = ~iSCLK;	// 20 ns period
	end

	// --------------------
	// Monitor and timeout
	// --------------------
	always @(negedge iSCLK)
	begin
		if (!iSRST && oVideoVd)
			rxWords.push_back(oVideoPixel);
		if (!iSRST && oHsValid)
			hdrCount++;	// Fields held, read later
	end

	always @(posedge iSCLK)
	begin
		cycleCnt++;
		if (cycleCnt >= lpMaxCycles)
		begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycleCnt);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic videoPkg::tPixelWord randWord();
		videoPkg::tPixelWord w;
		w = '0;
		for (int i = 0; i < 16; i++)
			w = {w[14:0], lfsrBit()};	// One step per bit
		return w;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	// --------------------
	// Lane driver
	// --------------------
	task automatic driveWord(input videoPkg::tPixelWord w);
		@(posedge iSCLK);
		#2;
		iRxValidHsLan0 = 1'b1;
		iRxValidHsLan1 = 1'b1;
		iRxDataHsLan0  = w[7:0];	// Byte 0 on lane0
		iRxDataHsLan1  = w[15:8];
	endtask

	task automatic idleLanes(input int n);
		repeat (n)
		begin
			@(posedge iSCLK);
			#2;
			iRxValidHsLan0 = 1'b0;
			iRxValidHsLan1 = 1'b0;
		end
	endtask

	// One burst, payload from txWords; stopAfter < 0 sends all plus CRC
	task automatic sendPacket(input csiProtoPkg::tDataType dt, input csiProtoPkg::tVc vc,
		input csiProtoPkg::tWordCnt wc, input csiProtoPkg::tEcc ecc, input int stopAfter);
		int nSend;
		nSend = txWords.size();
		if ((stopAfter >= 0) && (stopAfter < nSend))
			nSend = stopAfter;
		driveWord({wc[7:0], vc, dt});	// DI, WC low
		driveWord({ecc, wc[15:8]});		// WC high, ECC
		for (int i = 0; i < nSend; i++)
			driveWord(txWords[i]);
		if ((dt > csiProtoPkg::lpShortMax) && (stopAfter < 0))
			driveWord(randWord());	// CRC, never forwarded
		idleLanes(4);
	endtask

	task automatic genPayload(input int n);
		txWords.delete();
		rxWords.delete();
		repeat (n)
			txWords.push_back(randWord());
	endtask

	// Cycles from the early full flag rising to the overflow flag rising
	task automatic measureFullLead(output int n);
		n = 0;
		while (!oCdcFifoFull)
			@(negedge iSCLK);
		while (!oFifoOvf)
		begin
			@(negedge iSCLK);
			n++;
		end
	endtask

	// Waits for n words, then a quiet window to catch extras
	task automatic checkPayload(input int n);
		while (rxWords.size() < n)
			@(negedge iSCLK);
		repeat (lpSettle) @(negedge iSCLK);
		checkEq("pixel count", 32'(rxWords.size()), 32'(n));
		for (int i = 0; i < n; i++)
			checkEq("oVideoPixel", 32'(rxWords[i]), 32'(txWords[i]));
	endtask

	task automatic checkHeader(input int n, input csiProtoPkg::tDataType dt,
		input csiProtoPkg::tVc vc, input csiProtoPkg::tWordCnt wc, input csiProtoPkg::tEcc ecc);
		while (hdrCount < n)
			@(negedge iSCLK);
		checkEq("oHsValid count", 32'(hdrCount), 32'(n));
		checkEq("oHsDatatype", 32'(oHsDatatype), 32'(dt));
		checkEq("oHsVc", 32'(oHsVc), 32'(vc));
		checkEq("oHsWordCnt", 32'(oHsWordCnt), 32'(wc));
		checkEq("oHsEcc", 32'(oHsEcc), 32'(ecc));
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic testReset();
		@(negedge iSCLK);
		checkEq("oHsValid", 32'(oHsValid), 32'd0);
		checkEq("oVideoVd", 32'(oVideoVd), 32'd0);
		checkEq("oCdcFifoFull", 32'(oCdcFifoFull), 32'd0);
		checkEq("oFifoOvf", 32'(oFifoOvf), 32'd0);
		checkEq("oErrSot", 32'(oErrSot), 32'd0);
		checkEq("oErrTrunc", 32'(oErrTrunc), 32'd0);
	endtask

	task automatic testLongPacket();
		genPayload(10);					// 20 bytes
		sendPacket(6'h2B, 2'd1, 16'd20, 8'h3A, -1);
		checkPayload(10);
		checkHeader(1, 6'h2B, 2'd1, 16'd20, 8'h3A);
		genPayload(4);					// 7 bytes, last word padded
		sendPacket(6'h2A, 2'd0, 16'd7, 8'h15, -1);
		checkPayload(4);
		checkHeader(2, 6'h2A, 2'd0, 16'd7, 8'h15);
	endtask

	task automatic testShortPacket();
		genPayload(0);
		sendPacket(6'h00, 2'd2, 16'h0005, 8'h27, -1);	// Frame start, WC is data
		repeat (lpSettle) @(negedge iSCLK);
		checkHeader(3, 6'h00, 2'd2, 16'h0005, 8'h27);
		checkEq("pixel count", 32'(rxWords.size()), 32'd0);
	endtask

	task automatic testBackPressure();
		int lead;
		@(posedge iSCLK);
		#2 iVideoFull = 1'b1;
		genPayload(24);
		checkEq("oCdcFifoFull", 32'(oCdcFifoFull), 32'd0);
		fork
			sendPacket(6'h2B, 2'd3, 16'd48, 8'h0C, -1);
			measureFullLead(lead);
		join
		// One word per cycle, 12 to 16 held, then the lost write
		checkEq("oCdcFifoFull to oFifoOvf cycles", 32'(lead), 32'd5);
		checkEq("oCdcFifoFull", 32'(oCdcFifoFull), 32'd1);	// 16 held, level 12
		checkEq("pixel count", 32'(rxWords.size()), 32'd0);
		@(posedge iSCLK);
		#2 iVideoFull = 1'b0;
		checkPayload(16);	// Words beyond depth lost
		checkHeader(4, 6'h2B, 2'd3, 16'd48, 8'h0C);
		checkEq("oCdcFifoFull", 32'(oCdcFifoFull), 32'd0);
		checkEq("oFifoOvf", 32'(oFifoOvf), 32'd1);
	endtask

	task automatic testErrorFlags();
		checkEq("oErrTrunc", 32'(oErrTrunc), 32'd0);	// Clean so far
		checkEq("oErrSot", 32'(oErrSot), 32'd0);
		genPayload(10);
		sendPacket(6'h2B, 2'd0, 16'd20, 8'h41, 3);	// Stops after 3 words
		while (!oErrTrunc)
			@(negedge iSCLK);
		checkPayload(3);
		@(posedge iSCLK);
		#2 iErrSotHsLan1 = 1'b1;	// One cycle SOT error
		@(posedge iSCLK);
		#2 iErrSotHsLan1 = 1'b0;
		while (!oErrSot)
			@(negedge iSCLK);
		genPayload(4);
		sendPacket(6'h2B, 2'd2, 16'd8, 8'h5D, -1);
		checkPayload(4);
		checkHeader(6, 6'h2B, 2'd2, 16'd8, 8'h5D);
		checkEq("oErrTrunc", 32'(oErrTrunc), 32'd1);	// Still held
		checkEq("oErrSot", 32'(oErrSot), 32'd1);
	endtask

	initial
	begin
		lfsrState      = 32'h5e59;
		hdrCount       = 0;
		cycleCnt       = 0;
		iSRST          = 1'b1;
		iRxValidHsLan0 = 1'b0;
		iRxValidHsLan1 = 1'b0;
		iRxDataHsLan0  = '0;
		iRxDataHsLan1  = '0;
		iErrSotHsLan0  = 1'b0;
		iErrSotHsLan1  = 1'b0;
		iVideoFull     = 1'b0;
		repeat (3) @(posedge iSCLK);
		#2 iSRST = 1'b0;
		testReset();
		testLongPacket();
		testShortPacket();
		testBackPressure();
		testErrorFlags();
		if (i_csiRxController.i_csiRxController_sva.failCnt == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			$display("=== FAIL ===");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the CSI-2 receive testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module csiRxController_tb \
	-f csiRxController.f

./obj_dir/VcsiRxController_tb

// ==== src/csiLaneMerge.sv ====
`timescale 1ns/1ps
// CSI-2 two-lane merge
// Registers the HS byte lanes of the hard D-PHY and joins them into
// 16-bit words. Marks the first word of each burst and the cycle in
// which the combined valid falls. SOT errors of both lanes are kept
// in one sticky flag
module csiLaneMerge
(
	input	logic					iSCLK,
	input	logic					iSRST,
	// HS lane inputs
	input	logic					iRxValidHsLan0,
	input	logic					iRxValidHsLan1,
	input	csiProtoPkg::tLaneByte	iRxDataHsLan0,
	input	csiProtoPkg::tLaneByte	iRxDataHsLan1,
	input	logic					iErrSotHsLan0,
	input	logic					iErrSotHsLan1,
	// Merged word stream
	output	videoPkg::tPixelWord	oWord,
	output	logic					oWordVd,
	output	logic					oWordSop,
	output	logic					oBurstEnd,
	output	logic					oErrSot
);

	// --------------------
	// Lane capture
	// --------------------
	videoPkg::tPixelWord	rWord;		// {lane1, lane0}
	logic					rWordVd;	// Both lanes valid last cycle
	logic					rWordVdD;	// Previous combined valid
	logic					rErrSot;
	logic					wBothVd;

	// A cycle with one lane only is not a word
	assign wBothVd = iRxValidHsLan0 & iRxValidHsLan1;

	always_ff @(posedge iSCLK)
	begin
		if (wBothVd)
		begin
			rWord <= {iRxDataHsLan1, iRxDataHsLan0};	// Lane0 carries byte 0
		end
	end

	// --------------------
	// Burst framing
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rWordVd  <= 1'b0;
			rWordVdD <= 1'b0;
			rErrSot  <= 1'b0;
		end
		else
		begin
			rWordVd  <= wBothVd;
			rWordVdD <= rWordVd;
			// Either lane, held until reset
			rErrSot  <= rErrSot | iErrSotHsLan0 | iErrSotHsLan1;
		end
	end

	assign oWord     = rWord;
	assign oWordVd   = rWordVd;
	assign oWordSop  = rWordVd & ~rWordVdD;	// Rising edge, first word
	assign oBurstEnd = rWordVdD & ~rWordVd;	// Falling edge, no word here
	assign oErrSot   = rErrSot;

endmodule

// ==== src/csiPacketParser.sv ====
`timescale 1ns/1ps
// CSI-2 packet header parser
// Splits the first two words of a burst into data type, VC, word count
// and ECC. A long packet then passes its payload on as pixel words and
// the CRC word is dropped. Words after that are ignored until the burst
// ends. A burst that ends early sets a sticky truncation flag
module csiPacketParser
(
	input	logic					iSCLK,
	input	logic					iSRST,
	// Merged words from the lane stage
	input	videoPkg::tPixelWord	iWord,
	input	logic					iWordVd,
	input	logic					iWordSop,
	input	logic					iBurstEnd,
	// Header fields, held until the next header
	output	csiProtoPkg::tDataType	oHsDatatype,
	output	csiProtoPkg::tVc		oHsVc,
	output	csiProtoPkg::tWordCnt	oHsWordCnt,
	output	csiProtoPkg::tEcc		oHsEcc,
	output	logic					oHsValid,
	// Payload
	output	videoPkg::tPixelWord	oPix,
	output	logic					oPixVd,
	output	logic					oErrTrunc
);

	typedef enum logic [2:0]
	{
		stIdle,		// No burst, wait for SOP word
		stHdrLo,	// DI and WC low taken
		stHdrHi,	// Full header taken, strobe cycle
		stPayload,	// Pixel words
		stCrc,		// Next word is the CRC
		stDrain		// Rest of burst ignored
	} tState;

	tState					rState;
	csiProtoPkg::tLaneByte	rDiStage;	// First header byte, waits for the rest
	csiProtoPkg::tLaneByte	rWcLoStage;
	csiProtoPkg::tDataType	rDt;
	csiProtoPkg::tVc		rVc;
	csiProtoPkg::tWordCnt	rWc;
	csiProtoPkg::tEcc		rEcc;
	csiProtoPkg::tWordCnt	rPixLeft;	// Payload words still due
	videoPkg::tPixelWord	rPix;
	logic					rPixVd;
	logic					rErrTrunc;
	csiProtoPkg::tPktClass	wClass;
	logic [16:0]			wWcRound;	// WC plus rounding, no overflow
	logic					wInPayload;
	logic					wPixTake;
	logic					wPending;

	// --------------------
	// Decode
	// --------------------
	assign wClass = (rDt <= csiProtoPkg::lpShortMax) ? csiProtoPkg::pcShort
	                                                 : csiProtoPkg::pcLong;

	// Second header word holds WC high in its low byte
	assign wWcRound = {1'b0, iWord[7:0], rWcLoStage} + 17'(videoPkg::lpPixelBytes - 1);

	assign wInPayload = ((rState == stHdrHi) || (rState == stPayload))
	                    && (wClass == csiProtoPkg::pcLong) && (rPixLeft != '0);
	assign wPixTake   = wInPayload && iWordVd;
	// Header half done or payload short of its count
	assign wPending   = (rState == stHdrLo) || wInPayload;

	// --------------------
	// Control
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rState    <= stIdle;
			rPixLeft  <= '0;
			rPixVd    <= 1'b0;
			rErrTrunc <= 1'b0;
		end
		else
		begin
			rPixVd <= wPixTake;
			if (iBurstEnd && wPending)
			begin
				rErrTrunc <= 1'b1;	// Sticky until reset
			end

			if ((rState == stHdrLo) && iWordVd)
			begin
				rPixLeft <= csiProtoPkg::tWordCnt'(wWcRound / videoPkg::lpPixelBytes);
			end
			else if (wPixTake)
			begin
				rPixLeft <= rPixLeft - 1'b1;
			end

			if (iBurstEnd)
			begin
				rState <= stIdle;	// Burst over in any state
			end
			else
			begin
				case (rState)
					stIdle:
						if (iWordVd && iWordSop)
							rState <= stHdrLo;
					stHdrLo:
						if (iWordVd)
							rState <= stHdrHi;
					stHdrHi, stPayload:
						if (wClass == csiProtoPkg::pcShort)
							rState <= stDrain;	// No payload
						else if (rPixLeft == '0)
							rState <= iWordVd ? stDrain : stCrc;	// WC 0, word is CRC
						else if (wPixTake && (rPixLeft == 16'd1))
							rState <= stCrc;	// Last pixel
						else
							rState <= stPayload;
					stCrc:
						if (iWordVd)
							rState <= stDrain;	// CRC dropped
					stDrain:
						rState <= stDrain;
					default:
						rState <= stIdle;
				endcase
			end
		end
	end

	// --------------------
	// Header and pixel data
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if ((rState == stIdle) && iWordVd && iWordSop)
		begin
			rDiStage   <= iWord[7:0];
			rWcLoStage <= iWord[15:8];
		end
		if ((rState == stHdrLo) && iWordVd)
		begin
			// All fields update together
			rVc  <= rDiStage[7:6];
			rDt  <= rDiStage[5:0];
			rWc  <= {iWord[7:0], rWcLoStage};
			rEcc <= iWord[15:8];
		end
		if (wPixTake)
		begin
			rPix <= iWord;
		end
	end

	assign oHsDatatype = rDt;
	assign oHsVc       = rVc;
	assign oHsWordCnt  = rWc;
	assign oHsEcc      = rEcc;
	assign oHsValid    = (rState == stHdrHi);	// Always left after one cycle
	assign oPix        = rPix;
	assign oPixVd      = rPixVd;
	assign oErrTrunc   = rErrTrunc;

endmodule

// ==== src/csiProtoPkg.sv ====
// CSI-2 protocol definitions
// Header field types for the two-lane receive path, the short packet
// limit and the packet classes the header parser sorts into
package csiProtoPkg;

	// --------------------
	// Field widths
	// --------------------
	typedef logic [7:0]  tLaneByte;		// One HS byte per lane per cycle
	typedef logic [5:0]  tDataType;		// DI[5:0]
	typedef logic [15:0] tWordCnt;		// Payload length in bytes
	typedef logic [7:0]  tEcc;			// Header ECC, passed on unchecked
	typedef logic [1:0]  tVc;			// DI[7:6]

	// --------------------
	// Packet classes
	// --------------------
	// Sync and generic short packets sit at 0x00..0x0F
	// Anything above carries a payload and a 2-byte CRC
	localparam tDataType lpShortMax = 6'h0F;

	typedef enum logic
	{
		pcShort,	// Header only, WC field is data
		pcLong		// Header, WC bytes of payload, CRC
	} tPktClass;

endpackage

// ==== src/csiRxController.sv ====
`timescale 1ns/1ps
// CSI-2 two-lane receive controller
// Lane merge, header parser and pixel FIFO in a row on one clock.
// Header fields and error flags go straight out, pixels leave through
// the FIFO towards a sink that can push back
module csiRxController
#(
	parameter int pFifoDepth  = 64,
	parameter int pFullMargin = 4
)
(
	input	logic					iSCLK,
	input	logic					iSRST,
	// Hard D-PHY HS lanes
	input	logic					iRxValidHsLan0,
	input	logic					iRxValidHsLan1,
	input	csiProtoPkg::tLaneByte	iRxDataHsLan0,
	input	csiProtoPkg::tLaneByte	iRxDataHsLan1,
	input	logic					iErrSotHsLan0,
	input	logic					iErrSotHsLan1,
	// Packet header
	output	csiProtoPkg::tDataType	oHsDatatype,
	output	csiProtoPkg::tVc		oHsVc,
	output	csiProtoPkg::tWordCnt	oHsWordCnt,
	output	csiProtoPkg::tEcc		oHsEcc,
	output	logic					oHsValid,
	// Video sink
	output	videoPkg::tPixelWord	oVideoPixel,
	output	logic					oVideoVd,
	input	logic					iVideoFull,
	// Status
	output	logic					oCdcFifoFull,
	output	logic					oFifoOvf,
	output	logic					oErrSot,
	output	logic					oErrTrunc
);

	// --------------------
	// Lane merge
	// --------------------
	videoPkg::tPixelWord	wWord;
	logic					wWordVd;
	logic					wWordSop;
	logic					wBurstEnd;

	csiLaneMerge i_csiLaneMerge (
		.iSCLK(iSCLK),						.iSRST(iSRST),
		.iRxValidHsLan0(iRxValidHsLan0),	.iRxValidHsLan1(iRxValidHsLan1),
		.iRxDataHsLan0(iRxDataHsLan0),		.iRxDataHsLan1(iRxDataHsLan1),
		.iErrSotHsLan0(iErrSotHsLan0),		.iErrSotHsLan1(iErrSotHsLan1),
		.oWord(wWord),						.oWordVd(wWordVd),
		.oWordSop(wWordSop),				.oBurstEnd(wBurstEnd),
		.oErrSot(oErrSot)
	);

	// --------------------
	// Header parser
	// --------------------
	videoPkg::tPixelWord	wPix;
	logic					wPixVd;

	csiPacketParser i_csiPacketParser (
		.iSCLK(iSCLK),					.iSRST(iSRST),
		.iWord(wWord),					.iWordVd(wWordVd),
		.iWordSop(wWordSop),			.iBurstEnd(wBurstEnd),
		.oHsDatatype(oHsDatatype),		.oHsVc(oHsVc),
		.oHsWordCnt(oHsWordCnt),		.oHsEcc(oHsEcc),
		.oHsValid(oHsValid),
		.oPix(wPix),					.oPixVd(wPixVd),
		.oErrTrunc(oErrTrunc)
	);

	// --------------------
	// Pixel FIFO
	// --------------------
	pixelFifo #(
		.pFifoDepth(pFifoDepth),		.pFullMargin(pFullMargin)
	) i_pixelFifo (
		.iSCLK(iSCLK),					.iSRST(iSRST),
		.iWd(wPix),						.iWe(wPixVd),
		.iVideoFull(iVideoFull),
		.oRd(oVideoPixel),				.oRvd(oVideoVd),
		.oAlmostFull(oCdcFifoFull),		.oOvf(oFifoOvf)
	);

endmodule

// ==== src/pixelFifo.sv ====
`timescale 1ns/1ps
// Pixel FIFO towards the video sink
// Circular buffer with an occupancy count. Reads on its own whenever the
// sink has room and data is present; the word shows one cycle later.
// Early full from the count, sticky overflow on a write at full depth
module pixelFifo
#(
	parameter int pFifoDepth  = 64,
	parameter int pFullMargin = 4
)
(
	input	logic					iSCLK,
	input	logic					iSRST,
	// Write side, from the parser
	input	videoPkg::tPixelWord	iWd,
	input	logic					iWe,
	// Read side, sink
	input	logic					iVideoFull,
	output	videoPkg::tPixelWord	oRd,
	output	logic					oRvd,
	// Status
	output	logic					oAlmostFull,
	output	logic					oOvf
);

	localparam int lpAw      = (pFifoDepth > 1) ? $clog2(pFifoDepth) : 1;
	localparam int lpCw      = $clog2(pFifoDepth + 1);
	localparam int lpAfLevel = pFifoDepth - pFullMargin;	// Early full threshold

	videoPkg::tPixelWord	rMem [pFifoDepth];
	logic [lpAw-1:0]		rWrPtr;
	logic [lpAw-1:0]		rRdPtr;
	logic [lpCw-1:0]		rCount;
	videoPkg::tPixelWord	rRd;
	logic					rRvd;
	logic					rOvf;
	logic					wFull;
	logic					wWr;
	logic					wRe;

	// Wrap at depth, depth need not be a power of two
	function automatic logic [lpAw-1:0] nextPtr(input logic [lpAw-1:0] ptr);
		return (ptr == lpAw'(pFifoDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// --------------------
	// Flags
	// --------------------
	assign wFull = (rCount == lpCw'(pFifoDepth));
	assign wWr   = iWe & ~wFull;					// Write at full is lost
	assign wRe   = ~iVideoFull & (rCount != '0);	// Sink room and data

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rWrPtr <= '0;
			rRdPtr <= '0;
			rCount <= '0;
			rRvd   <= 1'b0;
			rOvf   <= 1'b0;
		end
		else
		begin
			rRvd <= wRe;
			if (iWe && wFull)
				rOvf <= 1'b1;	// Held until reset
			if (wWr)
				rWrPtr <= nextPtr(rWrPtr);
			if (wRe)
				rRdPtr <= nextPtr(rRdPtr);
			case ({wWr, wRe})
				2'b10:   rCount <= rCount + 1'b1;
				2'b01:   rCount <= rCount - 1'b1;
				default: rCount <= rCount;	// Both or neither
			endcase
		end
	end

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (wWr)
			rMem[rWrPtr] <= iWd;
		if (wRe)
			rRd <= rMem[rRdPtr];
	end

	assign oRd         = rRd;
	assign oRvd        = rRvd;
	assign oAlmostFull = (rCount >= lpCw'(lpAfLevel));
	assign oOvf        = rOvf;

endmodule

// ==== src/videoPkg.sv ====
// Pixel stream definitions
// Word type of the pixel path behind the header parser.
// A word is either two merged lane bytes or one 16-bit pixel
package videoPkg;

	// --------------------
	// Pixel word
	// --------------------
	typedef logic [15:0] tPixelWord;	// Lane1 byte high, lane0 byte low

	// Bytes carried by one merged word
	// Payload length in words is WC rounded up by this
	localparam int lpPixelBytes = 2;

endpackage
